/* files.f */
hw/frame_dma_pkg.sv
hw/dma_session_ctrl.sv
hw/bgrx_expander.sv
hw/color_bar_source.sv
hw/frame_dma_source.sv
verification/tb_frame_dma_source.sv

/* hw/bgrx_expander.sv */
//========================================
// Expands frame-buffer words of eight BGR565 pixels into BGRX word pairs
// Passes the word through unchanged in 565 mode
//========================================
module bgrx_expander #(
	parameter bit EXPAND_BGRX = 1'b1
) (
	input  logic                     pclk_div2,
	input  logic                     core_rst_n,
	input  logic                     i_fetch,
	input  logic                     i_phase,
	input  logic                     i_frame_done,
	input  frame_dma_pkg::dma_word_t i_frame_rd_data,
	output frame_dma_pkg::dma_word_t o_word
);

	frame_dma_pkg::dma_word_t hold_q;	// Frame word for the second half
	frame_dma_pkg::dma_word_t lo_bgrx;
	frame_dma_pkg::dma_word_t hi_bgrx;

	// Four 565 pixels to four BGRX pixels, pixel 0 at the bottom
	function automatic frame_dma_pkg::dma_word_t pack_bgrx(input logic [63:0] pix4);
		frame_dma_pkg::dma_word_t w;
		for (int i = 0; i < frame_dma_pkg::PIX_PER_WORD_BGRX; i++) begin
			w[i*32 +: 32] = frame_dma_pkg::bgr565_to_bgrx(pix4[i*16 +: 16]);
		end
		return w;
	endfunction

	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			hold_q <= '0;
		else if (i_frame_done)
			hold_q <= '0;
		else if (i_fetch)
			hold_q <= i_frame_rd_data;	// Same edge as the frame-buffer read
	end

	assign lo_bgrx = pack_bgrx(i_frame_rd_data[63:0]);	// Live word, low pixels
	assign hi_bgrx = pack_bgrx(hold_q[127:64]);

	generate
		if (EXPAND_BGRX) begin : g_bgrx
			assign o_word = i_phase ? hi_bgrx : lo_bgrx;
		end else begin : g_565
			assign o_word = i_frame_rd_data;
		end
	endgenerate

endmodule

/* hw/color_bar_source.sv */
//========================================
// Colour-bar test pattern that follows the DMA read position in the line
//========================================
module color_bar_source #(
	parameter int H_PIX       = 1280,
	parameter bit EXPAND_BGRX = 1'b1
) (
	input  logic                     pclk_div2,
	input  logic                     core_rst_n,
	input  logic                     i_addr_step,
	input  logic                     i_session_start,
	output frame_dma_pkg::dma_word_t o_word
);

	localparam int PPW = EXPAND_BGRX ? frame_dma_pkg::PIX_PER_WORD_BGRX
					: frame_dma_pkg::PIX_PER_WORD_565;
	localparam int WORDS_PER_LINE = H_PIX / PPW;
	localparam int WX_W           = $clog2(WORDS_PER_LINE + 1);
	localparam int BAR_W          = H_PIX / frame_dma_pkg::BAR_COUNT;	// Pixels per bar
	localparam int BAR_IDX_W      = $clog2(frame_dma_pkg::BAR_COUNT);

	logic [WX_W-1:0]       word_x;
	logic [BAR_IDX_W-1:0]  bar_idx;
	frame_dma_pkg::pix565_t bar_pix;

	// Red, green, blue, yellow, cyan, magenta, white, black
	function automatic frame_dma_pkg::pix565_t bar_color(input logic [BAR_IDX_W-1:0] idx);
		case (idx)
			0:       return 16'h001F;
			1:       return 16'h07E0;
			2:       return 16'hF800;
			3:       return 16'h07FF;
			4:       return 16'hFFE0;
			5:       return 16'hF81F;
			6:       return 16'hFFFF;
			default: return 16'h0000;
		endcase
	endfunction

	// Word position in the line
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			word_x <= '0;
		else if (i_session_start)
			word_x <= '0;
		else if (i_addr_step) begin
			if (word_x == WX_W'(WORDS_PER_LINE - 1))
				word_x <= '0;	// Line wrap
			else
				word_x <= word_x + 1'b1;
		end
	end

	// Bar from the first pixel of the current word
	always_comb begin
		int unsigned pix_x;
		pix_x   = word_x * PPW;
		bar_idx = '0;
		for (int i = 1; i < frame_dma_pkg::BAR_COUNT; i++) begin
			if (pix_x >= i * BAR_W)
				bar_idx = BAR_IDX_W'(i);
		end
	end

	assign bar_pix = bar_color(bar_idx);
	assign o_word  = EXPAND_BGRX ? {4{frame_dma_pkg::bgr565_to_bgrx(bar_pix)}} : {8{bar_pix}};

	a_word_x_range: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		word_x < WORDS_PER_LINE);

endmodule

/* hw/dma_session_ctrl.sv */
//========================================
// Read session control for the DMA frame source: word count, expand phase,
// read frame-sync stretch, stream-slave ready throttling and MSI request
//========================================
module dma_session_ctrl #(
	parameter int H_PIX       = 1280,
	parameter int V_LINES     = 720,
	parameter bit EXPAND_BGRX = 1'b1
) (
	input  logic                    pclk_div2,
	input  logic                    core_rst_n,
	input  logic                    i_rd_clk_en,
	input  frame_dma_pkg::rd_addr_t i_rd_addr,
	input  logic                    i_tx_restart,
	input  logic                    i_frame_done,
	input  logic                    i_slave_tvalid,
	input  logic                    i_slave_tready_raw,
	input  logic                    i_frame_rd_ready,
	input  logic                    i_msi_en,
	input  logic                    i_msi_grant,
	output logic                    o_addr_step,
	output logic                    o_session_start,
	output logic                    o_phase,
	output logic                    o_frame_rd_en,
	output logic                    o_rd_fsync,
	output logic                    o_slave_tready,
	output logic                    o_msi_req
);

	localparam int PPW = EXPAND_BGRX ? frame_dma_pkg::PIX_PER_WORD_BGRX
					: frame_dma_pkg::PIX_PER_WORD_565;
	localparam frame_dma_pkg::word_cnt_t FRAME_WORDS =
		frame_dma_pkg::word_cnt_t'(H_PIX * V_LINES / PPW);

	typedef enum logic {
		ST_IDLE,
		ST_READING
	} sess_state_t;

	sess_state_t               state;
	frame_dma_pkg::word_cnt_t  word_cnt;
	frame_dma_pkg::rd_addr_t   rd_addr_q;
	logic [4:0]                fsync_cnt;
	logic                      phase;
	logic                      first_beat;
	logic                      msi_pending;
	logic                      session_active;

	assign session_active  = (state == ST_READING);
	assign o_addr_step     = i_rd_clk_en && (i_rd_addr != rd_addr_q);
	assign o_session_start = i_tx_restart && !session_active;	// Restart ignored mid-session
	assign o_phase         = phase;

	// Second half of a BGRX pair comes from the hold register without a fetch
	assign o_frame_rd_en  = o_addr_step && session_active && (!EXPAND_BGRX || !phase);
	assign o_rd_fsync     = (fsync_cnt != '0);
	assign o_slave_tready = i_slave_tready_raw
				&& (!session_active || !first_beat || i_frame_rd_ready);
	assign o_msi_req      = msi_pending && i_msi_en;

	// Previous DMA address for step detection
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			rd_addr_q <= '0;
		else
			rd_addr_q <= i_rd_addr;
	end

	//========================================
	// Session state
	//========================================
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			state      <= ST_IDLE;
			word_cnt   <= '0;
			phase      <= 1'b0;
			first_beat <= 1'b0;
			fsync_cnt  <= '0;
		end else if (i_frame_done) begin
			// Frame done aborts everything including fsync
			state      <= ST_IDLE;
			word_cnt   <= '0;
			phase      <= 1'b0;
			first_beat <= 1'b0;
			fsync_cnt  <= '0;
		end else if (o_session_start) begin
			state      <= ST_READING;
			word_cnt   <= '0;
			phase      <= 1'b0;
			first_beat <= 1'b0;
			fsync_cnt  <= 5'(frame_dma_pkg::FSYNC_STRETCH);
		end else begin
			if (session_active && i_slave_tvalid && i_slave_tready_raw)
				first_beat <= 1'b1;

			if (session_active && o_addr_step) begin
				if (word_cnt == FRAME_WORDS - 1'b1) begin
					word_cnt <= '0;
					state    <= ST_IDLE;	// Last word of the frame
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
				if (EXPAND_BGRX)
					phase <= ~phase;
			end

			if (fsync_cnt != '0)
				fsync_cnt <= fsync_cnt - 1'b1;
		end
	end

	// Frame done beats grant for the MSI pending flag
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			msi_pending <= 1'b0;
		else if (i_frame_done)
			msi_pending <= 1'b1;
		else if (i_msi_grant)
			msi_pending <= 1'b0;
	end

	//========================================
	// Assertions
	//========================================
	a_word_cnt_range: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		word_cnt < FRAME_WORDS);

	// High phase only ever follows a fetch into the hold register
	a_high_phase_after_fetch: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		$rose(phase) |-> $past(o_frame_rd_en));

endmodule

/* hw/frame_dma_pkg.sv */
//========================================
// Shared pixel, word and counter types for the frame DMA source
// Referenced by scoped name from every RTL module
//========================================
package frame_dma_pkg;

	// Pixel and bus words
	typedef logic [15:0]  pix565_t;	// Blue [15:11], green [10:5], red [4:0]
	typedef logic [31:0]  pixbgrx_t;	// Pad, red, green, blue from the top
	typedef logic [127:0] dma_word_t;
	typedef logic [11:0]  rd_addr_t;	// DMA read address
	typedef logic [17:0]  word_cnt_t;	// Words per frame

	localparam int PIX_PER_WORD_565  = 8;
	localparam int PIX_PER_WORD_BGRX = 4;

	// Read frame-sync pulse length in cycles
	localparam int FSYNC_STRETCH = 31;

	localparam logic [7:0] BGRX_PAD = 8'h08;

	localparam int BAR_COUNT = 8;

	//========================================
	// Pixel widening
	//========================================
	// 5-bit fields repeat their top three bits below, 6-bit fields their top two
	function automatic pixbgrx_t bgr565_to_bgrx(input pix565_t pix);
		return {BGRX_PAD,
			pix[4:0], pix[4:2],		// Red
			pix[10:5], pix[10:9],		// Green
			pix[15:11], pix[15:13]};	// Blue
	endfunction

endpackage

/* hw/frame_dma_source.sv */
//========================================
// Frame data source for the PCIe DMA read path in the pclk_div2 domain
// Frame buffer and DMA engine attach through the ports
//========================================
module frame_dma_source #(
	parameter int H_PIX         = 1280,
	parameter int V_LINES       = 720,
	parameter bit EXPAND_BGRX   = 1'b1,
	parameter bit FORCE_PATTERN = 1'b0
) (
	input  logic                     pclk_div2,
	input  logic                     core_rst_n,
	// DMA engine
	input  logic                     i_rd_clk_en,
	input  frame_dma_pkg::rd_addr_t  i_rd_addr,
	input  logic                     i_tx_restart,
	input  logic                     i_frame_done,
	output frame_dma_pkg::dma_word_t o_rd_data,
	// Frame buffer
	input  frame_dma_pkg::dma_word_t i_frame_rd_data,
	input  logic                     i_frame_rd_ready,
	output logic                     o_frame_rd_en,
	output logic                     o_rd_fsync,
	// Stream slave 2
	input  logic                     i_slave_tvalid,
	input  logic                     i_slave_tready_raw,
	output logic                     o_slave_tready,
	// MSI
	input  logic                     i_msi_en,
	input  logic                     i_msi_grant,
	output logic                     o_msi_req
);

	logic                     addr_step;
	logic                     session_start;
	logic                     phase;
	frame_dma_pkg::dma_word_t frame_word;
	frame_dma_pkg::dma_word_t pattern_word;

	dma_session_ctrl #(
		.H_PIX              (H_PIX),
		.V_LINES            (V_LINES),
		.EXPAND_BGRX        (EXPAND_BGRX)
	) u_dma_session_ctrl (
		.pclk_div2          (pclk_div2),
		.core_rst_n         (core_rst_n),
		.i_rd_clk_en        (i_rd_clk_en),
		.i_rd_addr          (i_rd_addr),
		.i_tx_restart       (i_tx_restart),
		.i_frame_done       (i_frame_done),
		.i_slave_tvalid     (i_slave_tvalid),
		.i_slave_tready_raw (i_slave_tready_raw),
		.i_frame_rd_ready   (i_frame_rd_ready),
		.i_msi_en           (i_msi_en),
		.i_msi_grant        (i_msi_grant),
		.o_addr_step        (addr_step),
		.o_session_start    (session_start),
		.o_phase            (phase),
		.o_frame_rd_en      (o_frame_rd_en),
		.o_rd_fsync         (o_rd_fsync),
		.o_slave_tready     (o_slave_tready),
		.o_msi_req          (o_msi_req)
	);

	bgrx_expander #(
		.EXPAND_BGRX     (EXPAND_BGRX)
	) u_bgrx_expander (
		.pclk_div2       (pclk_div2),
		.core_rst_n      (core_rst_n),
		.i_fetch         (o_frame_rd_en),
		.i_phase         (phase),
		.i_frame_done    (i_frame_done),
		.i_frame_rd_data (i_frame_rd_data),
		.o_word          (frame_word)
	);

	color_bar_source #(
		.H_PIX           (H_PIX),
		.EXPAND_BGRX     (EXPAND_BGRX)
	) u_color_bar_source (
		.pclk_div2       (pclk_div2),
		.core_rst_n      (core_rst_n),
		.i_addr_step     (addr_step),
		.i_session_start (session_start),
		.o_word          (pattern_word)
	);

	assign o_rd_data = FORCE_PATTERN ? pattern_word : frame_word;	// Test pattern overrides

endmodule

/* verification/tb_frame_dma_source.sv */
//========================================
// Testbench for the frame DMA source, a BGRX instance and a colour-bar
// instance on shared random stimulus, checked against a cycle model
//========================================
module tb_frame_dma_source;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_PIX          = 64;
	localparam int V_LINES        = 2;
	localparam int SESSIONS       = 6;
	localparam int WORDS_BGRX     = H_PIX * V_LINES / 4;
	localparam int WORDS_565      = H_PIX * V_LINES / 8;
	// Steps come about every other cycle plus the idle tail of each session
	localparam int PLAN_CYCLES    = 10 + SESSIONS * (2 * WORDS_BGRX + 48);
	localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES;

	logic         pclk_div2;
	logic         core_rst_n;
	logic         i_rd_clk_en;
	logic [11:0]  i_rd_addr;
	logic         i_tx_restart;
	logic         i_frame_done;
	logic [127:0] i_frame_rd_data;
	logic         i_frame_rd_ready;
	logic         i_slave_tvalid;
	logic         i_slave_tready_raw;
	logic         i_msi_en;
	logic         i_msi_grant;

	// Outputs indexed 0 for the BGRX instance and 1 for the pattern instance
	logic [127:0] rd_data [2];
	logic         frame_rd_en [2];
	logic         rd_fsync [2];
	logic         slave_tready [2];
	logic         msi_req [2];

	// Model state
	logic         m_active [2];
	int           m_cnt [2];
	int           m_fsync [2];
	logic         m_first [2];
	logic         m_phase;	// BGRX instance only
	logic         m_pending;
	logic [127:0] m_hold;
	logic [11:0]  m_addr_q;
	int           m_word_x;	// Pattern word position in the line

	integer seed = 38376;
	int     cycle_cnt = 0;

	always #4 pclk_div2 = ~pclk_div2;

	frame_dma_source #(
		.H_PIX(H_PIX), .V_LINES(V_LINES), .EXPAND_BGRX(1'b1), .FORCE_PATTERN(1'b0)
	) u_frame_dma_source (
		.pclk_div2(pclk_div2), .core_rst_n(core_rst_n),
		.i_rd_clk_en(i_rd_clk_en), .i_rd_addr(i_rd_addr),
		.i_tx_restart(i_tx_restart), .i_frame_done(i_frame_done),
		.o_rd_data(rd_data[0]), .i_frame_rd_data(i_frame_rd_data),
		.i_frame_rd_ready(i_frame_rd_ready), .o_frame_rd_en(frame_rd_en[0]),
		.o_rd_fsync(rd_fsync[0]), .i_slave_tvalid(i_slave_tvalid),
		.i_slave_tready_raw(i_slave_tready_raw), .o_slave_tready(slave_tready[0]),
		.i_msi_en(i_msi_en), .i_msi_grant(i_msi_grant), .o_msi_req(msi_req[0])
	);

	frame_dma_source #(
		.H_PIX(H_PIX), .V_LINES(V_LINES), .EXPAND_BGRX(1'b0), .FORCE_PATTERN(1'b1)
	) u_frame_dma_source_pattern (
		.pclk_div2(pclk_div2), .core_rst_n(core_rst_n),
		.i_rd_clk_en(i_rd_clk_en), .i_rd_addr(i_rd_addr),
		.i_tx_restart(i_tx_restart), .i_frame_done(i_frame_done),
		.o_rd_data(rd_data[1]), .i_frame_rd_data(i_frame_rd_data),
		.i_frame_rd_ready(i_frame_rd_ready), .o_frame_rd_en(frame_rd_en[1]),
		.o_rd_fsync(rd_fsync[1]), .i_slave_tvalid(i_slave_tvalid),
		.i_slave_tready_raw(i_slave_tready_raw), .o_slave_tready(slave_tready[1]),
		.i_msi_en(i_msi_en), .i_msi_grant(i_msi_grant), .o_msi_req(msi_req[1])
	);

	//========================================
	// Reference functions
	//========================================
	// Pad, red, green, blue with top bits repeated below each field
	function automatic logic [31:0] widen_pixel(input logic [15:0] p);
		return {8'h08, p[4:0], p[4:2], p[10:5], p[10:9], p[15:11], p[15:13]};
	endfunction

	function automatic logic [127:0] expand_four(input logic [63:0] pix4);
		logic [127:0] w;
		for (int i = 0; i < 4; i++)
			w[i*32 +: 32] = widen_pixel(pix4[i*16 +: 16]);
		return w;
	endfunction

	function automatic logic [15:0] bar_colour(input int idx);
		case (idx)
			0:       return 16'h001F;
			1:       return 16'h07E0;
			2:       return 16'hF800;
			3:       return 16'h07FF;
			4:       return 16'hFFE0;
			5:       return 16'hF81F;
			6:       return 16'hFFFF;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic int words_for(input int inst);
		return (inst == 0) ? WORDS_BGRX : WORDS_565;
	endfunction

	task automatic check_value(input string name, input logic [127:0] actual,
				   input logic [127:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "Output mismatch at %0t", $time);
		end
	endtask

	//========================================
	// Stimulus, checks and model update
	//========================================
	task automatic drive_inputs(input logic restart, input logic done);
		i_tx_restart       = restart;
		i_frame_done       = done;
		i_frame_rd_data    = {$random(seed), $random(seed), $random(seed), $random(seed)};
		i_frame_rd_ready   = ($random(seed) & 3) != 0;
		i_slave_tvalid     = ($random(seed) & 1) != 0;
		i_slave_tready_raw = ($random(seed) & 3) != 0;
		i_msi_en           = ($random(seed) & 3) != 0;
		i_msi_grant        = ($random(seed) & 7) == 0;
		if (($random(seed) & 1) != 0) begin
			i_rd_clk_en = 1'b1;
			i_rd_addr   = i_rd_addr + 1'b1;	// Address step
		end else if (($random(seed) & 1) != 0) begin
			i_rd_clk_en = 1'b0;
			i_rd_addr   = i_rd_addr + 1'b1;	// Moves with the enable low so no step
		end else begin
			i_rd_clk_en = ($random(seed) & 1) != 0;	// Same address so no step
		end
	endtask

	task automatic check_outputs;
		logic         step;
		logic [127:0] exp_data;
		int           bar;
		step     = i_rd_clk_en && (i_rd_addr != m_addr_q);
		exp_data = m_phase ? expand_four(m_hold[127:64]) : expand_four(i_frame_rd_data[63:0]);
		bar      = (m_word_x * 8) / (H_PIX / 8);
		check_value("o_rd_data", rd_data[0], exp_data);
		check_value("o_rd_data (pattern)", rd_data[1], {8{bar_colour(bar)}});
		check_value("o_frame_rd_en", frame_rd_en[0], step && m_active[0] && !m_phase);
		check_value("o_frame_rd_en (pattern)", frame_rd_en[1], step && m_active[1]);
		for (int i = 0; i < 2; i++) begin
			check_value("o_rd_fsync", rd_fsync[i], m_fsync[i] != 0);
			check_value("o_slave_tready", slave_tready[i], i_slave_tready_raw
				    && (!m_active[i] || !m_first[i] || i_frame_rd_ready));
			check_value("o_msi_req", msi_req[i], m_pending && i_msi_en);
		end
	endtask

	task automatic update_model;
		logic step;
		logic start;
		step = i_rd_clk_en && (i_rd_addr != m_addr_q);
		if (i_tx_restart && !m_active[1])
			m_word_x = 0;
		else if (step)
			m_word_x = (m_word_x == H_PIX / 8 - 1) ? 0 : m_word_x + 1;
		if (i_frame_done)
			m_hold = '0;
		else if (step && m_active[0] && !m_phase)
			m_hold = i_frame_rd_data;
		for (int i = 0; i < 2; i++) begin
			start = i_tx_restart && !m_active[i];
			if (i_frame_done || start) begin
				m_active[i] = !i_frame_done;
				m_cnt[i]    = 0;
				m_first[i]  = 1'b0;
				m_fsync[i]  = i_frame_done ? 0 : 31;
				if (i == 0)
					m_phase = 1'b0;
			end else begin
				if (m_active[i] && i_slave_tvalid && i_slave_tready_raw)
					m_first[i] = 1'b1;
				if (m_active[i] && step) begin
					if (m_cnt[i] == words_for(i) - 1) begin
						m_cnt[i]    = 0;
						m_active[i] = 1'b0;
					end else begin
						m_cnt[i]++;
					end
					if (i == 0)
						m_phase = ~m_phase;
				end
				if (m_fsync[i] != 0)
					m_fsync[i]--;
			end
		end
		if (i_frame_done)
			m_pending = 1'b1;
		else if (i_msi_grant)
			m_pending = 1'b0;
		m_addr_q = i_rd_addr;
	endtask

	task automatic run_cycle(input logic restart, input logic done);
		@(posedge pclk_div2);
		#1;
		drive_inputs(restart, done);
		#2;
		check_outputs();
		update_model();
	endtask

	always @(posedge pclk_div2) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	initial begin
		int n;
		pclk_div2          = 1'b0;
		core_rst_n         = 1'b0;
		i_rd_clk_en        = 1'b0;
		i_rd_addr          = '0;
		i_tx_restart       = 1'b0;
		i_frame_done       = 1'b0;
		i_frame_rd_data    = '0;
		i_frame_rd_ready   = 1'b0;
		i_slave_tvalid     = 1'b0;
		i_slave_tready_raw = 1'b0;
		i_msi_en           = 1'b0;
		i_msi_grant        = 1'b0;
		for (int i = 0; i < 2; i++) begin
			m_active[i] = 1'b0;
			m_cnt[i]    = 0;
			m_fsync[i]  = 0;
			m_first[i]  = 1'b0;
		end
		m_phase   = 1'b0;
		m_pending = 1'b0;
		m_hold    = '0;
		m_addr_q  = '0;
		m_word_x  = 0;
		repeat (10) @(posedge pclk_div2);
		#1;
		core_rst_n = 1'b1;

		for (int s = 0; s < SESSIONS; s++) begin
			run_cycle(1'b1, 1'b0);
			n = 0;
			// Restart mid-session is ignored and session 3 is aborted inside fsync
			while (m_active[0] || m_active[1]) begin
				run_cycle(n == 5, s == 3 && n == 12);
				n++;
			end
			repeat (40) run_cycle(1'b0, 1'b0);	// Steps with no session
			run_cycle(1'b0, 1'b1);	// Raise MSI
			repeat (6) run_cycle(1'b0, 1'b0);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule
